// ==== verilog/pid_pkg.sv ====
/*
  shared widths, shifts and register field codes for the MIMO PID
  setpoint and gains are signed CW-bit values, the integrator is IW wide
  shift amounts fix the gain scaling and are not run time settings
*/

package pid_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // setpoint and gain register width, two's complement
  localparam int unsigned CW = 14;

  // integrator accumulator, clipped not wrapped
  localparam int unsigned IW = 32;

  //////////////////////////////////////////////////
  // product scaling
  //////////////////////////////////////////////////

  localparam int unsigned PSR = 12;  // kp product shift
  localparam int unsigned ISR = 18;  // integrator output shift
  localparam int unsigned DSR = 10;  // kd difference shift

  //////////////////////////////////////////////////
  // per-block register fields, address bits 3:2
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FIELD_SP = 2'd0,  // setpoint
    FIELD_KP = 2'd1,  // proportional gain
    FIELD_KI = 2'd2,  // integral gain
    FIELD_KD = 2'd3   // derivative gain
  } reg_field_e;

endpackage

// ==== verilog/pid_regs.sv ====
/*
  setting registers for the PID array, full 32-bit word writes only
  CNI and CNO must be powers of two, CNO*CNI no more than 32
  every access is acknowledged one cycle later, no error response
*/

`timescale 1ns/1ns

module pid_regs #(
  parameter int unsigned CNI = 2,  // input channels
  parameter int unsigned CNO = 2   // output channels
) (
  input  logic                                      clk_i,
  input  logic                                      rstn_i,
  // system bus
  input  logic [31:0]                               sys_addr_i,
  input  logic [31:0]                               sys_wdata_i,
  input  logic                                      sys_wen_i,
  input  logic                                      sys_ren_i,
  output logic [31:0]                               sys_rdata_o,
  output logic                                      sys_ack_o,
  output logic                                      sys_err_o,
  // settings, one entry per output/input pair
  output logic [CNO-1:0][CNI-1:0][pid_pkg::CW-1:0]  set_sp_o,
  output logic [CNO-1:0][CNI-1:0][pid_pkg::CW-1:0]  set_kp_o,
  output logic [CNO-1:0][CNI-1:0][pid_pkg::CW-1:0]  set_ki_o,
  output logic [CNO-1:0][CNI-1:0][pid_pkg::CW-1:0]  set_kd_o,
  output logic [CNO-1:0][CNI-1:0]                   irst_o
);

  localparam int unsigned CW  = pid_pkg::CW;
  localparam int unsigned CLI = $clog2(CNI);
  localparam int unsigned CLO = $clog2(CNO);
  localparam int unsigned PW  = CLO + CLI;  // pair index width
  localparam int unsigned NP  = CNO * CNI;  // number of pairs

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  logic                 blk_sel;  // 1: per-block space, 0: integrator reset word
  logic [PW-1:0]        pair;     // {o, i}, matches o*CNI+i
  pid_pkg::reg_field_e  field;

  assign blk_sel = sys_addr_i[4+PW];
  assign pair    = sys_addr_i[4+PW-1:4];
  assign field   = pid_pkg::reg_field_e'(sys_addr_i[3:2]);

  //////////////////////////////////////////////////
  // setting storage, flat by pair index
  //////////////////////////////////////////////////

  logic [NP-1:0][CW-1:0] sp_q;
  logic [NP-1:0][CW-1:0] kp_q;
  logic [NP-1:0][CW-1:0] ki_q;
  logic [NP-1:0][CW-1:0] kd_q;
  logic [NP-1:0]         irst_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      sp_q   <= '0;
      kp_q   <= '0;
      ki_q   <= '0;
      kd_q   <= '0;
      irst_q <= '1;  // integrators held after reset
    end else if (sys_wen_i) begin
      if (!blk_sel) begin
        irst_q <= sys_wdata_i[NP-1:0];  // one bit per pair
      end else begin
        case (field)
          pid_pkg::FIELD_SP: sp_q[pair] <= sys_wdata_i[CW-1:0];
          pid_pkg::FIELD_KP: kp_q[pair] <= sys_wdata_i[CW-1:0];
          pid_pkg::FIELD_KI: ki_q[pair] <= sys_wdata_i[CW-1:0];
          pid_pkg::FIELD_KD: kd_q[pair] <= sys_wdata_i[CW-1:0];
        endcase
      end
    end
  end

  // flat pair order equals [o][i] packing
  assign set_sp_o = sp_q;
  assign set_kp_o = kp_q;
  assign set_ki_o = ki_q;
  assign set_kd_o = kd_q;
  assign irst_o   = irst_q;

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////

  logic [CW-1:0] fld_rd;  // addressed field of addressed pair
  logic [31:0]   rdata_q;
  logic          ack_q;

  always_comb begin
    case (field)
      pid_pkg::FIELD_SP: fld_rd = sp_q[pair];
      pid_pkg::FIELD_KP: fld_rd = kp_q[pair];
      pid_pkg::FIELD_KI: fld_rd = ki_q[pair];
      pid_pkg::FIELD_KD: fld_rd = kd_q[pair];
    endcase
  end

  // sampled on the read strobe, zero extended
  always_ff @(posedge clk_i) begin
    if (sys_ren_i) begin
      if (!blk_sel) begin
        rdata_q <= {{(32-NP){1'b0}}, irst_q};
      end else begin
        rdata_q <= {{(32-CW){1'b0}}, fld_rd};
      end
    end
  end

  // ack one cycle after any strobe
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_wen_i | sys_ren_i;
    end
  end

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign sys_err_o   = 1'b0;  // no error responses

endmodule

// ==== verilog/pid_block.sv ====
/*
  single PID controller, dat_i to dat_o in 3 clocks
  integrator clears while irst_i is high and clips at the IW range
  no derivative filter, output clipped to signed DW range
*/

`timescale 1ns/1ns

module pid_block #(
  parameter int unsigned DW = 14  // data width
) (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  input  logic signed [DW-1:0]          dat_i,
  input  logic signed [pid_pkg::CW-1:0] set_sp_i,
  input  logic signed [pid_pkg::CW-1:0] set_kp_i,
  input  logic signed [pid_pkg::CW-1:0] set_ki_i,
  input  logic signed [pid_pkg::CW-1:0] set_kd_i,
  input  logic                          irst_i,
  output logic signed [DW-1:0]          dat_o
);

  localparam int unsigned CW  = pid_pkg::CW;
  localparam int unsigned IW  = pid_pkg::IW;
  localparam int unsigned EW  = ((DW > CW) ? DW : CW) + 1;  // error, no overflow
  localparam int unsigned MW  = EW + CW;                    // gain products
  localparam int unsigned DFW = MW + 1;                     // kd difference
  localparam int unsigned AW  = IW + 1;                     // integrator sum
  localparam int unsigned SW  = IW + 2;                     // term sum

  //////////////////////////////////////////////////
  // stage 1: error
  //////////////////////////////////////////////////

  logic signed [EW-1:0] err_q;

  always_ff @(posedge clk_i) begin
    err_q <= EW'(set_sp_i) - EW'(dat_i);
  end

  //////////////////////////////////////////////////
  // stage 2: P, I and D terms
  //////////////////////////////////////////////////

  logic signed [MW-1:0]  kp_mul, ki_mul, kd_mul;
  logic signed [MW-1:0]  p_q;
  logic signed [MW-1:0]  kd_prev_q;  // last err*kd
  logic signed [DFW-1:0] d_diff;
  logic signed [DFW-1:0] d_q;
  logic signed [AW-1:0]  int_sum;
  logic signed [IW-1:0]  int_q;
  logic signed [IW-1:0]  i_term;

  assign kp_mul = MW'(err_q) * MW'(set_kp_i);
  assign ki_mul = MW'(err_q) * MW'(set_ki_i);
  assign kd_mul = MW'(err_q) * MW'(set_kd_i);

  assign d_diff  = DFW'(kd_mul) - DFW'(kd_prev_q);
  assign int_sum = AW'(int_q) + AW'(ki_mul);  // one guard bit for clipping

  always_ff @(posedge clk_i) begin
    p_q <= kp_mul >>> pid_pkg::PSR;
    d_q <= d_diff >>> pid_pkg::DSR;
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      kd_prev_q <= '0;
    end else begin
      kd_prev_q <= kd_mul;
    end
  end

  // accumulator, held at zero by irst_i
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      int_q <= '0;
    end else if (irst_i) begin
      int_q <= '0;
    end else if (int_sum[AW-1] != int_sum[AW-2]) begin
      // overflow, pin to the signed limit of the sum's sign
      int_q <= int_sum[AW-1] ? {1'b1, {(IW-1){1'b0}}} : {1'b0, {(IW-1){1'b1}}};
    end else begin
      int_q <= int_sum[IW-1:0];
    end
  end

  assign i_term = int_q >>> pid_pkg::ISR;

  //////////////////////////////////////////////////
  // stage 3: sum and clip
  //////////////////////////////////////////////////

  logic signed [SW-1:0] pid_sum;
  logic signed [DW-1:0] out_q;

  assign pid_sum = SW'(p_q) + SW'(i_term) + SW'(d_q);

  always_ff @(posedge clk_i) begin
    if (!pid_sum[SW-1] && (|pid_sum[SW-2:DW-1])) begin
      out_q <= {1'b0, {(DW-1){1'b1}}};   // max positive
    end else if (pid_sum[SW-1] && !(&pid_sum[SW-2:DW-1])) begin
      out_q <= {1'b1, {(DW-1){1'b0}}};   // min negative
    end else begin
      out_q <= pid_sum[DW-1:0];
    end
  end

  assign dat_o = out_q;

endmodule

// ==== verilog/pid_sum_sat.sv ====
/*
  adds the CNI terms of each output and clips to the signed DW range
  one clock of latency, outputs are 0 after reset
*/

`timescale 1ns/1ns

module pid_sum_sat #(
  parameter int unsigned DW  = 14,  // data width
  parameter int unsigned CNI = 2,   // terms per output
  parameter int unsigned CNO = 2    // outputs
) (
  input  logic                                clk_i,
  input  logic                                rstn_i,
  input  logic signed [CNO-1:0][CNI-1:0][DW-1:0] term_i,
  output logic signed [CNO-1:0][DW-1:0]          dat_o
);

  localparam int unsigned SW = DW + $clog2(CNI);  // sum cannot overflow

  for (genvar o = 0; o < CNO; o++) begin : g_out
    logic signed [SW-1:0] sum;
    logic signed [DW-1:0] out_q;

    always_comb begin
      logic signed [DW-1:0] term;  // slice of packed array is unsigned
      sum = '0;
      for (int i = 0; i < CNI; i++) begin
        term = term_i[o][i];
        sum  = sum + SW'(term);
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
        out_q <= '0;
      end else if (!sum[SW-1] && (|sum[SW-2:DW-1])) begin
        out_q <= {1'b0, {(DW-1){1'b1}}};  // positive clip
      end else if (sum[SW-1] && !(&sum[SW-2:DW-1])) begin
        out_q <= {1'b1, {(DW-1){1'b0}}};  // negative clip
      end else begin
        out_q <= sum[DW-1:0];
      end
    end

    assign dat_o[o] = out_q;
  end

endmodule

// ==== verilog/pid_mimo.sv ====
/*
  MIMO PID top, CNO x CNI controllers summed per output
  dat_i to dat_o in 4 clocks, one sample per clock, no valid signal
  CNI and CNO are powers of two, at least 2
*/

`timescale 1ns/1ns

module pid_mimo #(
  parameter int unsigned DW  = 14,  // data width
  parameter int unsigned CNI = 2,   // input channels
  parameter int unsigned CNO = 2    // output channels
) (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  input  logic signed [CNI-1:0][DW-1:0] dat_i,
  output logic signed [CNO-1:0][DW-1:0] dat_o,
  // system bus
  input  logic [31:0]                   sys_addr_i,
  input  logic [31:0]                   sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [31:0]                   sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o
);

  logic [CNO-1:0][CNI-1:0][pid_pkg::CW-1:0] set_sp, set_kp, set_ki, set_kd;
  logic [CNO-1:0][CNI-1:0]                  irst;
  logic [CNO-1:0][CNI-1:0][DW-1:0]          term;  // block outputs

  //////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////

  pid_regs #(
    .CNI (CNI),
    .CNO (CNO)
  ) regs0 (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .set_sp_o    (set_sp),
    .set_kp_o    (set_kp),
    .set_ki_o    (set_ki),
    .set_kd_o    (set_kd),
    .irst_o      (irst)
  );

  //////////////////////////////////////////////////
  // PID array, column i sees input channel i
  //////////////////////////////////////////////////

  for (genvar o = 0; o < CNO; o++) begin : g_row
    for (genvar i = 0; i < CNI; i++) begin : g_col
      pid_block #(
        .DW (DW)
      ) blk (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .dat_i    (dat_i[i]),
        .set_sp_i (set_sp[o][i]),
        .set_kp_i (set_kp[o][i]),
        .set_ki_i (set_ki[o][i]),
        .set_kd_i (set_kd[o][i]),
        .irst_i   (irst[o][i]),
        .dat_o    (term[o][i])
      );
    end
  end

  pid_sum_sat #(
    .DW  (DW),
    .CNI (CNI),
    .CNO (CNO)
  ) sum0 (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .term_i (term),
    .dat_o  (dat_o)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
/*
  clock and reset source for the testbench
  reset is released on a rising edge so the DUT sees it synchronously
*/

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 20,  // ns
  parameter int RST_CYCLES = 4    // edges with reset low
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rstn_o <= 1'b0;  // active low
    repeat (RST_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

// ==== bench/tb_pid_mimo.sv ====
/*
  testbench for pid_mimo at the default DW, CNI and CNO
  a cycle model predicts dat_o and the bus replies, assertions compare
  stimulus uses a fixed seed, a watchdog bounds the run
*/

`timescale 1ns/1ns

module tb_pid_mimo;

  localparam int DW     = 14;
  localparam int CNI    = 2;
  localparam int CNO    = 2;
  localparam int CW     = pid_pkg::CW;
  localparam int NP     = CNO * CNI;                  // controller pairs
  localparam int PW     = $clog2(CNO) + $clog2(CNI);  // pair index bits
  localparam int PERIOD = 20;
  localparam int P_N    = 200;  // proportional samples
  localparam int SAT_N  = 64;   // saturation samples
  localparam int ID_N   = 60;   // samples per integrator release
  localparam int TEST_CYCLES = 42 + NP * (42 + ID_N) + P_N + SAT_N + ID_N;
  localparam int WD_NS  = (2 * TEST_CYCLES + 100) * PERIOD;  // double plus margin
  localparam logic [DW-1:0] DMAX = {1'b0, {(DW-1){1'b1}}};
  localparam logic [DW-1:0] DMIN = {1'b1, {(DW-1){1'b0}}};

  logic                   clk;
  logic                   rstn;
  logic [CNI-1:0][DW-1:0] din;
  logic [CNO-1:0][DW-1:0] dout;
  logic [31:0]            sys_addr;
  logic [31:0]            sys_wdata;
  logic [31:0]            sys_rdata;
  logic                   sys_wen;
  logic                   sys_ren;
  logic                   sys_ack;
  logic                   sys_err;
  integer                 seed = 63;

  tb_clk_gen #(.PERIOD (PERIOD), .RST_CYCLES (4)) clk0 (.clk_o (clk), .rstn_o (rstn));

  pid_mimo #(.DW (DW), .CNI (CNI), .CNO (CNO)) dut0 (
    .clk_i       (clk),
    .rstn_i      (rstn),
    .dat_i       (din),
    .dat_o       (dout),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err)
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  logic [NP-1:0][CW-1:0]  m_sp, m_kp, m_ki, m_kd;  // model settings
  logic [NP-1:0]          m_irst;
  longint                 m_err [NP];
  longint                 m_p [NP];
  longint                 m_d [NP];
  longint                 m_kdprev [NP];          // previous err*kd
  longint                 m_int [NP];
  longint                 m_out [NP];             // per block term
  logic [CNO-1:0][DW-1:0] exp_dat;
  logic [31:0]            exp_rdata;
  logic                   exp_ack;
  logic                   exp_rd_vld;
  logic                   rstn_q = 1'b0;
  logic                   chk_arm = 1'b0;
  logic                   chk_en = 1'b0;          // first edge has X in the pipe

  function automatic longint clip(input longint x, input int w);
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (w - 1)) - 1;
    lo = -(longint'(1) <<< (w - 1));
    if (x > hi) return hi;
    if (x < lo) return lo;
    return x;
  endfunction

  // stages updated back to front, each reads last cycle's state
  always @(posedge clk) begin : ref_model
    longint acc;
    longint kd_prod;
    int     pa;
    for (int o = 0; o < CNO; o++) begin
      acc = 0;
      for (int i = 0; i < CNI; i++) begin
        acc += m_out[o*CNI+i];
      end
      exp_dat[o] = rstn ? DW'(clip(acc, DW)) : '0;  // summer resets
    end
    for (int p = 0; p < NP; p++) begin
      m_out[p] = clip(m_p[p] + (m_int[p] >>> pid_pkg::ISR) + m_d[p], DW);
      kd_prod  = m_err[p] * longint'($signed(m_kd[p]));
      m_p[p]   = (m_err[p] * longint'($signed(m_kp[p]))) >>> pid_pkg::PSR;
      m_d[p]   = (kd_prod - m_kdprev[p]) >>> pid_pkg::DSR;
      if (!rstn) m_kdprev[p] = 0;
      else m_kdprev[p] = kd_prod;
      if (!rstn || m_irst[p]) m_int[p] = 0;  // held while reset bit set
      else m_int[p] = clip(m_int[p] + m_err[p] * longint'($signed(m_ki[p])), pid_pkg::IW);
      m_err[p] = longint'($signed(m_sp[p])) - longint'($signed(din[p % CNI]));
    end
    // bus side
    pa         = int'(sys_addr[3+PW:4]);
    exp_ack    = rstn & (sys_wen | sys_ren);
    exp_rd_vld = sys_ren;
    if (sys_ren) begin
      if (!sys_addr[4+PW]) begin
        exp_rdata = 32'(m_irst);
      end else begin
        case (pid_pkg::reg_field_e'(sys_addr[3:2]))
          pid_pkg::FIELD_SP: exp_rdata = 32'(m_sp[pa]);
          pid_pkg::FIELD_KP: exp_rdata = 32'(m_kp[pa]);
          pid_pkg::FIELD_KI: exp_rdata = 32'(m_ki[pa]);
          pid_pkg::FIELD_KD: exp_rdata = 32'(m_kd[pa]);
        endcase
      end
    end
    if (!rstn) begin
      m_sp   = '0;
      m_kp   = '0;
      m_ki   = '0;
      m_kd   = '0;
      m_irst = '1;
    end else if (sys_wen) begin
      if (!sys_addr[4+PW]) begin
        m_irst = sys_wdata[NP-1:0];
      end else begin
        case (pid_pkg::reg_field_e'(sys_addr[3:2]))
          pid_pkg::FIELD_SP: m_sp[pa] = sys_wdata[CW-1:0];
          pid_pkg::FIELD_KP: m_kp[pa] = sys_wdata[CW-1:0];
          pid_pkg::FIELD_KI: m_ki[pa] = sys_wdata[CW-1:0];
          pid_pkg::FIELD_KD: m_kd[pa] = sys_wdata[CW-1:0];
        endcase
      end
    end
  end

  always @(posedge clk) begin
    rstn_q  <= rstn;
    chk_arm <= 1'b1;
    chk_en  <= chk_arm;
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  int dat_errs [CNO];
  int ack_errs = 0;
  int rd_errs  = 0;
  int err_errs = 0;
  int rst_errs = 0;

  for (genvar o = 0; o < CNO; o++) begin : g_dat_chk
    initial dat_errs[o] = 0;
    a_dat: assert property (@(posedge clk) disable iff (!chk_en) dout[o] == exp_dat[o])
      else begin
        dat_errs[o]++;
        $display("CHECK FAILED at %0t: dat_o[%0d] expected %0d, actual %0d", $time, o,
                 $signed($sampled(exp_dat[o])), $signed($sampled(dout[o])));
      end
  end

  a_ack: assert property (@(posedge clk) disable iff (!chk_en) sys_ack == exp_ack)
    else begin
      ack_errs++;
      $display("CHECK FAILED at %0t: sys_ack_o expected %b, actual %b", $time,
               $sampled(exp_ack), $sampled(sys_ack));
    end

  a_rdata: assert property (@(posedge clk) disable iff (!chk_en)
                            !exp_rd_vld || sys_rdata == exp_rdata)
    else begin
      rd_errs++;
      $display("CHECK FAILED at %0t: sys_rdata_o expected %h, actual %h", $time,
               $sampled(exp_rdata), $sampled(sys_rdata));
    end

  a_err: assert property (@(posedge clk) disable iff (!chk_en) sys_err == 1'b0)
    else begin
      err_errs++;
      $display("CHECK FAILED at %0t: sys_err_o expected 0, actual %b", $time,
               $sampled(sys_err));
    end

  // outputs quiet on the cycle after a reset edge
  a_rst: assert property (@(posedge clk) disable iff (!chk_en)
                          rstn_q || (dout == '0 && !sys_ack))
    else begin
      rst_errs++;
      $display("CHECK FAILED at %0t: dat_o/sys_ack_o expected 0/0 in reset, actual %h/%b",
               $time, $sampled(dout), $sampled(sys_ack));
    end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand_amp(input int amp);
    return 32'($random(seed) % amp);  // -(amp-1) .. amp-1
  endfunction

  function automatic logic [31:0] blk_addr(input int p, input int f);
    return (32'd1 << (4 + PW)) | 32'(p << 4) | 32'(f << 2);
  endfunction

  task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
    @(posedge clk);
    sys_addr  <= a;
    sys_wdata <= d;
    sys_wen   <= 1'b1;
    @(posedge clk);
    sys_wen   <= 1'b0;  // one cycle strobe
  endtask

  task automatic bus_read(input logic [31:0] a);
    @(posedge clk);
    sys_addr <= a;
    sys_ren  <= 1'b1;
    @(posedge clk);
    sys_ren  <= 1'b0;
  endtask

  task automatic load_pair(input int p, input logic [31:0] sp, input logic [31:0] kp,
                           input logic [31:0] ki, input logic [31:0] kd);
    bus_write(blk_addr(p, pid_pkg::FIELD_SP), sp);
    bus_write(blk_addr(p, pid_pkg::FIELD_KP), kp);
    bus_write(blk_addr(p, pid_pkg::FIELD_KI), ki);
    bus_write(blk_addr(p, pid_pkg::FIELD_KD), kd);
  endtask

  task automatic drive_samples(input int n, input int amp);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      for (int c = 0; c < CNI; c++) begin
        din[c] <= DW'(rand_amp(amp));
      end
    end
  endtask

  task automatic drive_extremes(input int n);
    int sel;
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      for (int c = 0; c < CNI; c++) begin
        sel = $random(seed) & 3;
        din[c] <= (sel == 0) ? DMAX : (sel == 1) ? DMIN : DW'(rand_amp(8192));
      end
    end
  endtask

  initial begin : stimulus
    int          total;
    logic [31:0] mask;
    din       <= '0;
    sys_addr  <= '0;
    sys_wdata <= '0;
    sys_wen   <= 1'b0;
    sys_ren   <= 1'b0;
    while (rstn !== 1'b1) @(posedge clk);
    bus_read(32'h0);  // integrator reset word after reset
    // register access, every field of every pair
    for (int p = 0; p < NP; p++) begin
      for (int f = 0; f < 4; f++) begin
        bus_write(blk_addr(p, f), $random(seed));
        bus_read(blk_addr(p, f));
      end
    end
    bus_write(32'h0, $random(seed));
    bus_read(32'h0);
    bus_write(32'h0, 32'hffff_ffff);  // integrators held again
    // proportional only
    for (int p = 0; p < NP; p++) begin
      load_pair(p, rand_amp(8192), rand_amp(2048), 0, 0);
    end
    drive_samples(P_N, 8192);
    // full scale gains, row 0 pulled negative and row 1 positive
    for (int p = 0; p < NP; p++) begin
      load_pair(p, (p % 2) ? 32'h1fff : 32'h2000,
                ((p % 2) != ((p / CNI) % 2)) ? 32'h2000 : 32'h1fff, 0, 0);
    end
    drive_extremes(SAT_N);
    // integral and derivative, integrators released one by one
    for (int p = 0; p < NP; p++) begin
      load_pair(p, rand_amp(1024), rand_amp(1024), rand_amp(256) | 32'd1,
                rand_amp(2048) | 32'd1);
    end
    mask = '1;
    for (int p = 0; p < NP; p++) begin
      mask[p] = 1'b0;
      bus_write(32'h0, mask);
      drive_samples(ID_N, 2048);
    end
    bus_read(32'h0);
    bus_write(32'h0, 32'hffff_ffff);  // back to P plus D
    drive_samples(ID_N, 2048);
    repeat (8) @(posedge clk);  // drain pipeline
    @(negedge clk);
    total = ack_errs + rd_errs + err_errs + rst_errs;
    for (int o = 0; o < CNO; o++) begin
      total += dat_errs[o];
    end
    $display("summary: %0d errors (dat_o %0d/%0d, ack %0d, rdata %0d, err %0d, reset %0d)",
             total, dat_errs[0], dat_errs[CNO-1], ack_errs, rd_errs, err_errs, rst_errs);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WD_NS);
    $display("watchdog: run did not complete within %0d ns", WD_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/pid_pkg.sv
verilog/pid_regs.sv
verilog/pid_block.sv
verilog/pid_sum_sat.sv
verilog/pid_mimo.sv
bench/tb_clk_gen.sv
bench/tb_pid_mimo.sv

// ==== Makefile ====
# Verilator build and run for the pid_mimo testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TB_TOP    = tb_pid_mimo
RTL_TOP   = pid_mimo
FILELIST  = verilog.f
OBJDIR    = obj_dir
PASS_MSG  = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
